// File: flist.f
frontend_pkg.sv
pc_gen.sv
fetch_budget.sv
pre_decode.sv
instr_queue.sv
frontend_top.sv
tb_clock.sv
tb_frontend_sva.sv
tb_frontend.sv

// File: run.sh
#!/bin/bash
# Build the front end testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log
top=tb_frontend

if ! verilator --binary --timing --assert -f flist.f --top-module "$top" \
	--Mdir obj_dir -o sim_frontend; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_frontend +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if grep -q "^Regression passed$" "$log"; then
	exit 0
else
	echo "Pass message not found in $log"
	exit 1
fi

// File: tb_frontend.sv
// Front end testbench top
// Memory model with a hashed byte fill and patched branch encodings,
// golden pc walk over the same bytes, four tests, watchdog and report
`timescale 1ns/1ns

module tb_frontend;

	localparam int          depth   = 4;
	localparam logic [63:0] boot_pc = 64'h8000_0000;
	localparam logic [31:0] seed    = 32'ha949_2ddb;
	localparam int          n_instr = 200;
	localparam longint      wd_ns   = 4 * n_instr * 12 * 40;	// Tests x instr x cycles x period

	logic        CLK, reset, flush, req_valid, req_ready, rsp_valid;
	logic        dec_valid, dec_ready, dec_is_rvc, dec_pred_taken;
	logic [63:0] flush_pc, req_addr, rsp_data, dec_pc, pend_addr, exp_pc;
	logic [31:0] dec_instr, rng;
	frontend_pkg::br_kind_e dec_kind;
	logic [7:0]  patch [logic [63:0]];	// Hand placed encodings
	int          pops, errors, cnt, base_err, n_pass, n_fail;
	bit          ready_rand;

	tb_clock u_clock (.CLK(CLK), .reset(reset));

	frontend_top #(.depth(depth), .boot_pc(boot_pc)) UUT (
		.CLK(CLK), .reset(reset), .flush(flush), .flush_pc(flush_pc),
		.req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data),
		.dec_valid(dec_valid), .dec_ready(dec_ready), .dec_pc(dec_pc),
		.dec_instr(dec_instr), .dec_is_rvc(dec_is_rvc), .dec_kind(dec_kind),
		.dec_pred_taken(dec_pred_taken)
	);

	bind frontend_top tb_frontend_sva #(.depth(depth)) u_sva (
		.CLK(CLK), .reset(reset), .flush(flush), .req_valid(req_valid),
		.req_ready(req_ready), .req_addr(req_addr), .rsp_valid(rsp_valid),
		.dec_valid(dec_valid), .dec_ready(dec_ready), .dec_pc(dec_pc),
		.dec_instr(dec_instr), .dec_kind(dec_kind), .dec_is_rvc(dec_is_rvc),
		.issue(issue), .enq(enq), .deq(deq)
	);

	// ******************************
	// Random source and memory
	// ******************************
	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] rand_next();
		rng = xorshift(rng);
		return rng;
	endfunction

	// Fill hashes the whole 64-bit address
	function automatic logic [7:0] mem_byte(logic [63:0] a);
		logic [31:0] h;
		if (patch.exists(a)) return patch[a];
		h = xorshift(xorshift(a[31:0] ^ a[63:32] ^ seed));
		return h[7:0];
	endfunction

	task automatic put(logic [63:0] a, logic [31:0] v, int nbytes);
		for (int k = 0; k < nbytes; k++) patch[a + 64'(k)] = v[8*k +: 8];
	endtask

	// ******************************
	// Golden walk
	// ******************************
	function automatic frontend_pkg::br_kind_e classify(logic [31:0] i);
		logic link_rd, link_rs1;
		link_rd  = (i[11:7] == 5'd1) || (i[11:7] == 5'd5);	// Same field as c rs1
		link_rs1 = (i[19:15] == 5'd1) || (i[19:15] == 5'd5);
		if (i[1:0] == 2'b11) begin
			if (i[6:0] == 7'h6f) return link_rd ? frontend_pkg::br_call : frontend_pkg::br_jal;
			if (i[6:0] == 7'h67 && i[14:12] == 3'd0) begin
				if (link_rd) return frontend_pkg::br_call;
				if (i[11:7] == 5'd0 && link_rs1) return frontend_pkg::br_ret;
				return frontend_pkg::br_jalr;
			end
			if (i[6:0] == 7'h63 && i[14:13] != 2'b01) return frontend_pkg::br_cond;
		end else if (i[1:0] == 2'b01) begin
			if (i[15:13] == 3'b101) return frontend_pkg::br_jal;		// c.j
			if (i[15:14] == 2'b11) return frontend_pkg::br_cond;		// c.beqz c.bnez
		end else if (i[1:0] == 2'b10 && i[15:12] inside {4'b1000, 4'b1001}
			&& i[11:7] != 5'd0 && i[6:2] == 5'd0) begin
			if (i[12]) return frontend_pkg::br_call;
			return link_rd ? frontend_pkg::br_ret : frontend_pkg::br_jalr;
		end
		return frontend_pkg::br_none;
	endfunction

	task automatic fail_value(string msg);
		$display("[FAIL] %0t ns %s", $time, msg);
		errors++;
	endtask

	task automatic check_entry();
		logic [31:0] i;
		logic [63:0] off;
		frontend_pkg::br_kind_e k;
		i = {mem_byte(exp_pc + 3), mem_byte(exp_pc + 2), mem_byte(exp_pc + 1), mem_byte(exp_pc)};
		k = classify(i);
		assert (dec_pc == exp_pc) else fail_value($sformatf("pc %h, expected %h", dec_pc, exp_pc));
		assert (dec_instr == i) else fail_value($sformatf("instr %h, expected %h", dec_instr, i));
		assert (dec_is_rvc == (i[1:0] != 2'b11)) else fail_value("compressed flag wrong");
		assert (dec_kind == k) else fail_value($sformatf("kind %0d, expected %0d", dec_kind, k));
		assert (dec_pred_taken == (k == frontend_pkg::br_jal)) else fail_value("taken flag wrong");
		if (i[1:0] == 2'b11) off = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
		else off = {{53{i[12]}}, i[8], i[10:9], i[6], i[7], i[2], i[11], i[5:3], 1'b0};
		if (k == frontend_pkg::br_jal) exp_pc = exp_pc + off;	// Direct jumps redirect
		else exp_pc = exp_pc + ((i[1:0] == 2'b11) ? 64'd4 : 64'd2);
	endtask

	always @(posedge CLK) begin
		if (!reset && dec_valid === 1'b1 && dec_ready) begin
			check_entry();
			pops++;
		end
		if (!reset && flush) exp_pc = flush_pc;	// After a same-edge pop
	end

	// ******************************
	// Memory and decoder drive
	// ******************************
	initial begin
		logic take;
		forever begin
			@(posedge CLK);
			take = !reset && req_valid && req_ready;
			if (take) pend_addr = req_addr;
			#5;
			rsp_valid = 1'b0;
			if (take) cnt = 1 + int'(rand_next() % 3);		// 1 to 3 cycles later
			if (cnt != 0) begin
				cnt--;
				if (cnt == 0) begin
					rsp_valid = 1'b1;
					for (int k = 0; k < 8; k++) rsp_data[8*k +: 8] = mem_byte(pend_addr + 64'(k));
				end
			end
			req_ready = rand_next() % 2 == 0;
			dec_ready = ready_rand ? (rand_next() % 4 == 0) : 1'b1;	// Mostly stalled, fills queue
		end
	end

	// ******************************
	// Test sequence
	// ******************************
	task automatic tick();
		@(posedge CLK);
		#5;
	endtask

	task automatic do_flush(logic [63:0] pc);
		flush    = 1'b1;
		flush_pc = pc;
		tick();
		flush = 1'b0;
	endtask

	task automatic wait_pops(int n);
		int target;
		target = pops + n;
		while (pops < target) tick();
	endtask

	function automatic int total_errors();
		return errors + UUT.u_sva.fails;
	endfunction

	task automatic end_test(string name);
		if (total_errors() == base_err) n_pass++;
		else n_fail++;
		$display("Test %-10s %0d entries popped, %0d errors", name, pops,
			total_errors() - base_err);
		base_err = total_errors();
	endtask

	initial begin
		logic [31:0] r;
		int          goal;	// Pop count that ends the flush test
		rng        = seed;
		flush      = 1'b0;
		flush_pc   = '0;
		req_ready  = 1'b0;
		rsp_valid  = 1'b0;
		rsp_data   = '0;
		dec_ready  = 1'b0;
		ready_rand = 1'b0;
		exp_pc     = boot_pc;
		cnt        = 0;
		pops       = 0;
		errors     = 0;
		base_err   = 0;
		n_pass     = 0;
		n_fail     = 0;
		put(boot_pc,       32'h0080_006f, 4);	// jal x0, +8
		put(boot_pc + 8,   32'h0000_a019, 2);	// c.j +6
		put(boot_pc + 14,  32'h0000_0863, 4);	// beq, upper half of a word
		put(boot_pc + 18,  32'h0040_00ef, 4);	// jal x1 is a call
		put(boot_pc + 22,  32'h0000_8067, 4);	// ret
		put(boot_pc + 26,  32'h0000_8082, 2);	// c.jr x1
		put(boot_pc + 28,  32'h0000_9282, 2);	// c.jalr x5
		put(boot_pc + 30,  32'h0003_0067, 4);	// jalr x0, 0(x6)
		put(boot_pc + 34,  32'h0000_c001, 2);	// c.beqz
		put(boot_pc + 36,  32'h1000_006f, 4);	// jal into hashed bytes
		@(posedge CLK);
		while (reset) begin
			@(posedge CLK);
			assert (req_valid === 1'b0 && dec_valid === 1'b0)
				else fail_value("valid high during reset or idle");
		end
		while (req_valid !== 1'b1) @(posedge CLK);
		assert (req_addr == {boot_pc[63:2], 2'b00})
			else fail_value($sformatf("first request %h", req_addr));
		#5;
		wait_pops(1);
		end_test("reset");
		wait_pops(n_instr);
		end_test("stream");
		ready_rand = 1'b1;
		do_flush(boot_pc);
		wait_pops(n_instr);
		end_test("stall");
		goal = pops + n_instr;
		while (pops < goal) begin
			r = rand_next();
			repeat (int'(r[3:0])) tick();
			do_flush(boot_pc + {52'd0, r[15:5], 1'b0});
		end
		end_test("flush");
		$display("Tests %0d passed, %0d failed, %0d errors", n_pass, n_fail, total_errors());
		if (n_fail == 0 && total_errors() == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(wd_ns);
		$display("Watchdog expired before all tests finished");
		$display("Regression failed");
		$finish;
	end

endmodule

// File: tb_frontend_sva.sv
// Front end protocol assertions
// Bound into the top level, checks request and decoder handshakes
// and that queued plus in-flight work never exceeds the queue depth
`timescale 1ns/1ns

module tb_frontend_sva #(
	parameter int depth = 4
) (
	input logic        CLK,
	input logic        reset,
	input logic        flush,
	input logic        req_valid,
	input logic        req_ready,
	input logic [63:0] req_addr,
	input logic        rsp_valid,
	input logic        dec_valid,
	input logic        dec_ready,
	input logic [63:0] dec_pc,
	input logic [31:0] dec_instr,
	input logic [2:0]  dec_kind,
	input logic        dec_is_rvc,
	input logic        issue,
	input logic        enq,
	input logic        deq
);

	int fails = 0;	// Read by the testbench top
	int qcnt;		// Entries held in the queue
	int pend;		// Fetch outstanding

	always_ff @(posedge CLK) begin
		if (reset) begin
			qcnt <= 0;
			pend <= 0;
		end else begin
			qcnt <= flush ? 0 : qcnt + int'(enq) - int'(deq);	// Flush empties queue
			if (issue) pend <= 1;
			else if (rsp_valid) pend <= 0;
		end
	end

	// ******************************
	// Handshake rules
	// ******************************
	a_reset_quiet: assert property (@(posedge CLK) $past(reset) |-> !req_valid && !dec_valid)
		else begin $error("request or decoder valid high out of reset"); fails++; end

	a_req_hold: assert property (@(posedge CLK) disable iff (reset)
		req_valid && !req_ready && !flush |=> req_valid && $stable(req_addr))
		else begin $error("fetch request dropped or changed before transfer"); fails++; end

	a_dec_hold: assert property (@(posedge CLK) disable iff (reset)
		dec_valid && !dec_ready && !flush |=> dec_valid && $stable(dec_pc)
		&& $stable(dec_instr) && $stable(dec_kind) && $stable(dec_is_rvc))
		else begin $error("decoder entry changed while stalled"); fails++; end

	a_budget: assert property (@(posedge CLK) disable iff (reset) qcnt + pend <= depth)
		else begin $error("queued plus in-flight work exceeds queue depth"); fails++; end

endmodule

// File: tb_clock.sv
// Testbench clock and reset source
// 40 ns clock, reset held high for the first 10 rising edges
`timescale 1ns/1ns

module tb_clock (
	output logic CLK,
	output logic reset
);

	initial begin
		CLK   = 1'b0;
		reset = 1'b1;
		forever #20 CLK = ~CLK;	// 40 ns period
	end

	initial begin
		repeat (10) @(posedge CLK);
		#5 reset = 1'b0;	// Released off the edge like all stimulus
	end

endmodule

// File: frontend_top.sv
// Instruction front end top level
// Connects the pc state machine, the slot budget and the instruction
// queue between the instruction memory and the decoder
`timescale 1ns/1ns

module frontend_top #(
	parameter int                            depth   = 4,
	parameter logic [frontend_pkg::xlen-1:0] boot_pc = 64'h8000_0000
) (
	input  logic                             CLK,
	input  logic                             reset,
	input  logic                             flush,
	input  logic [frontend_pkg::xlen-1:0]    flush_pc,
	// Fetch request
	output logic                             req_valid,
	input  logic                             req_ready,
	output logic [frontend_pkg::xlen-1:0]    req_addr,
	// Fetch response, never back-pressured
	input  logic                             rsp_valid,
	input  logic [frontend_pkg::fetch_w-1:0] rsp_data,
	// Decoder
	output logic                             dec_valid,
	input  logic                             dec_ready,
	output logic [frontend_pkg::xlen-1:0]    dec_pc,
	output logic [frontend_pkg::ilen-1:0]    dec_instr,
	output logic                             dec_is_rvc,
	output frontend_pkg::br_kind_e           dec_kind,
	output logic                             dec_pred_taken
);

	logic                          enq, issue, drop, in_flight;
	logic                          has_room, deq;
	logic [frontend_pkg::xlen-1:0] cur_pc, next_pc;

	// ******************************
	// Fetch control
	// ******************************
	pc_gen #(.boot_pc(boot_pc)) u_pc_gen (
		.CLK       (CLK),
		.reset     (reset),
		.flush     (flush),
		.flush_pc  (flush_pc),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.next_pc   (next_pc),
		.has_room  (has_room),
		.req_valid (req_valid),
		.req_addr  (req_addr),
		.cur_pc    (cur_pc),
		.enq       (enq),
		.issue     (issue),
		.drop      (drop),
		.in_flight (in_flight)
	);

	fetch_budget #(.depth(depth)) u_fetch_budget (
		.CLK       (CLK),
		.reset     (reset),
		.flush     (flush),
		.issue     (issue),
		.deq       (deq),
		.drop      (drop),
		.in_flight (in_flight),
		.has_room  (has_room)
	);

	// ******************************
	// Queue toward decoder
	// ******************************
	instr_queue #(.depth(depth)) u_instr_queue (
		.CLK            (CLK),
		.reset          (reset),
		.flush          (flush),
		.enq            (enq),
		.cur_pc         (cur_pc),
		.rsp_data       (rsp_data),
		.dec_ready      (dec_ready),
		.next_pc        (next_pc),
		.deq            (deq),
		.dec_valid      (dec_valid),
		.dec_pc         (dec_pc),
		.dec_instr      (dec_instr),
		.dec_is_rvc     (dec_is_rvc),
		.dec_kind       (dec_kind),
		.dec_pred_taken (dec_pred_taken)
	);

endmodule

// File: instr_queue.sv
// Instruction queue
// Aligns one instruction out of the 64-bit fetch window by pc bit 1,
// tags it through the pre-decoder and keeps entries in a circular FIFO
// that feeds the decoder under valid/ready
// Also returns the next fetch pc to the pc state machine
`timescale 1ns/1ns

module instr_queue #(
	parameter int depth = 4
) (
	input  logic                             CLK,
	input  logic                             reset,
	input  logic                             flush,
	input  logic                             enq,
	input  logic [frontend_pkg::xlen-1:0]    cur_pc,
	input  logic [frontend_pkg::fetch_w-1:0] rsp_data,
	input  logic                             dec_ready,
	output logic [frontend_pkg::xlen-1:0]    next_pc,
	output logic                             deq,
	output logic                             dec_valid,
	output logic [frontend_pkg::xlen-1:0]    dec_pc,
	output logic [frontend_pkg::ilen-1:0]    dec_instr,
	output logic                             dec_is_rvc,
	output frontend_pkg::br_kind_e           dec_kind,
	output logic                             dec_pred_taken
);

	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);

	logic [frontend_pkg::ilen-1:0] align_instr;
	logic                          is_rvc;
	frontend_pkg::br_kind_e        kind;
	logic [frontend_pkg::xlen-1:0] target;

	// Entry storage
	logic [frontend_pkg::xlen-1:0] pc_mem    [depth];
	logic [frontend_pkg::ilen-1:0] instr_mem [depth];
	logic                          rvc_mem   [depth];
	frontend_pkg::br_kind_e        kind_mem  [depth];
	logic                          taken_mem [depth];

	logic [aw-1:0] wr_ptr, rd_ptr;
	logic [cw-1:0] count;

	// ******************************
	// Align and pre-decode
	// ******************************
	assign align_instr = cur_pc[1] ? rsp_data[47:16] : rsp_data[31:0];	// Bytes 2..5 or 0..3

	pre_decode u_pre_decode (
		.instr  (align_instr),
		.cur_pc (cur_pc),
		.is_rvc (is_rvc),
		.kind   (kind),
		.imm    (),
		.target (target)
	);

	// Only direct jumps redirect, everything else falls through
	assign next_pc = (kind == frontend_pkg::br_jal) ? target :
		cur_pc + (is_rvc ? 64'd2 : 64'd4);

	// ******************************
	// FIFO
	// ******************************
	assign dec_valid = (count != '0);
	assign deq       = dec_valid & dec_ready;

	always_ff @(posedge CLK) begin
		if (enq) begin	// Budget keeps the write slot free
			pc_mem[wr_ptr]    <= cur_pc;
			instr_mem[wr_ptr] <= align_instr;
			rvc_mem[wr_ptr]   <= is_rvc;
			kind_mem[wr_ptr]  <= kind;
			taken_mem[wr_ptr] <= (kind == frontend_pkg::br_jal);
		end
	end

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (enq) wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (deq) rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + cw'(enq) - cw'(deq);
		end
	end

	// Head entry, held while the decoder stalls
	assign dec_pc         = pc_mem[rd_ptr];
	assign dec_instr      = instr_mem[rd_ptr];
	assign dec_is_rvc     = rvc_mem[rd_ptr];
	assign dec_kind       = kind_mem[rd_ptr];
	assign dec_pred_taken = taken_mem[rd_ptr];

endmodule

// File: pre_decode.sv
// Branch pre-decoder
// Sorts an aligned instruction into a branch kind, builds the
// sign-extended immediate of jumps and branches and the direct target
// Handles jal, jalr, beq..bgeu and c.j, c.jr, c.jalr, c.beqz, c.bnez
`timescale 1ns/1ns

module pre_decode (
	input  logic [frontend_pkg::ilen-1:0] instr,
	input  logic [frontend_pkg::xlen-1:0] cur_pc,
	output logic                          is_rvc,
	output frontend_pkg::br_kind_e        kind,
	output logic [frontend_pkg::xlen-1:0] imm,
	output logic [frontend_pkg::xlen-1:0] target
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [4:0] rd, rs1;
	logic [2:0] c_funct3;
	logic       rd_link, rs1_link;
	logic       c_rs1_link;

	assign opcode   = instr[6:0];
	assign funct3   = instr[14:12];
	assign rd       = instr[11:7];
	assign rs1      = instr[19:15];
	assign c_funct3 = instr[15:13];

	assign is_rvc = (instr[1:0] != 2'b11);	// Low bits 11 mark a 32-bit form

	// Link registers x1 and x5
	assign rd_link    = (rd == 5'd1) | (rd == 5'd5);
	assign rs1_link   = (rs1 == 5'd1) | (rs1 == 5'd5);
	assign c_rs1_link = (instr[11:7] == 5'd1) | (instr[11:7] == 5'd5);

	// ******************************
	// Classification and immediate
	// ******************************
	always_comb begin
		kind = frontend_pkg::br_none;
		imm  = '0;
		if (!is_rvc) begin
			case (opcode)
				7'b1101111: begin	// jal
					kind = rd_link ? frontend_pkg::br_call : frontend_pkg::br_jal;
					imm  = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
						instr[30:21], 1'b0};
				end
				7'b1100111: begin	// jalr
					if (funct3 == 3'b000) begin
						if (rd_link) kind = frontend_pkg::br_call;
						else if (rd == 5'd0 && rs1_link) kind = frontend_pkg::br_ret;
						else kind = frontend_pkg::br_jalr;
					end
					imm = {{52{instr[31]}}, instr[31:20]};	// Offset to rs1, not pc
				end
				7'b1100011: begin	// beq bne blt bge bltu bgeu
					if (funct3 != 3'b010 && funct3 != 3'b011) kind = frontend_pkg::br_cond;
					imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
						instr[11:8], 1'b0};
				end
				default: ;
			endcase
		end else if (instr[1:0] == 2'b01) begin
			if (c_funct3 == 3'b101) begin	// c.j
				kind = frontend_pkg::br_jal;
				imm  = {{52{instr[12]}}, instr[12], instr[8], instr[10:9], instr[6],
					instr[7], instr[2], instr[11], instr[5:3], 1'b0};
			end else if (c_funct3[2:1] == 2'b11) begin	// c.beqz c.bnez
				kind = frontend_pkg::br_cond;
				imm  = {{55{instr[12]}}, instr[12], instr[6:5], instr[2], instr[11:10],
					instr[4:3], 1'b0};
			end
		end else if (instr[1:0] == 2'b10) begin
			// c.jr and c.jalr need rs1 nonzero and rs2 zero
			if (c_funct3 == 3'b100 && instr[11:7] != 5'd0 && instr[6:2] == 5'd0) begin
				if (instr[12]) kind = frontend_pkg::br_call;	// c.jalr links x1
				else if (c_rs1_link) kind = frontend_pkg::br_ret;
				else kind = frontend_pkg::br_jalr;
			end
		end
	end

	assign target = cur_pc + imm;	// Only meaningful for pc relative forms

endmodule

// File: fetch_budget.sv
// Queue slot budget
// Counts queue slots that are neither promised to a fetch nor holding
// an entry, so a fetch is only issued when its result has a place
`timescale 1ns/1ns

module fetch_budget #(
	parameter int depth = 4
) (
	input  logic CLK,
	input  logic reset,
	input  logic flush,
	input  logic issue,		// Request transfer takes a slot
	input  logic deq,		// Pop toward decoder frees one
	input  logic drop,		// Drained response frees one
	input  logic in_flight,	// Fetch outstanding across this edge
	output logic has_room
);

	localparam int cw = $clog2(depth + 1);

	logic [cw-1:0] slots;

	// ******************************
	// Up/down counter
	// ******************************
	always_ff @(posedge CLK) begin
		if (reset) begin
			slots <= cw'(depth);	// Queue empty, nothing in flight
		end else if (flush) begin
			// Queue empties, an outstanding fetch keeps its slot until drained
			slots <= cw'(depth) - cw'(in_flight);
		end else begin
			slots <= slots + cw'(deq) + cw'(drop) - cw'(issue);
		end
	end

	assign has_room = (slots != '0);

endmodule

// File: pc_gen.sv
// Program counter state machine
// Holds the fetch pc, issues one fetch at a time when the queue budget
// allows, loads the next pc from the queue once the response lands and
// drains a fetch that was in flight when a flush arrived
`timescale 1ns/1ns

module pc_gen #(
	parameter logic [frontend_pkg::xlen-1:0] boot_pc = 64'h8000_0000
) (
	input  logic                          CLK,
	input  logic                          reset,
	input  logic                          flush,
	input  logic [frontend_pkg::xlen-1:0] flush_pc,
	input  logic                          req_ready,
	input  logic                          rsp_valid,
	input  logic [frontend_pkg::xlen-1:0] next_pc,
	input  logic                          has_room,
	output logic                          req_valid,
	output logic [frontend_pkg::xlen-1:0] req_addr,
	output logic [frontend_pkg::xlen-1:0] cur_pc,
	output logic                          enq,
	output logic                          issue,
	output logic                          drop,
	output logic                          in_flight
);

	typedef enum logic [1:0] {
		s_idle,		// One cycle after reset
		s_issue,	// Request pending or waiting for room
		s_wait_rsp,	// One fetch outstanding
		s_drain		// Outstanding fetch belongs to a flushed path
	} state_e;

	state_e state, state_nxt;
	logic [frontend_pkg::xlen-1:0] pc_q, pc_nxt;

	// ******************************
	// Handshake outputs
	// ******************************
	assign req_valid = (state == s_issue) & has_room;	// Room never drops once raised
	assign issue     = req_valid & req_ready;
	assign req_addr  = {pc_q[frontend_pkg::xlen-1:2], 2'b00};	// Word aligned window
	assign cur_pc    = pc_q;

	// Response lands in the queue only on the live path
	assign enq  = (state == s_wait_rsp) & rsp_valid & ~flush;
	assign drop = rsp_valid & ((state == s_drain) | ((state == s_wait_rsp) & flush));

	// Still outstanding after this edge, new transfer included
	assign in_flight = issue | (((state == s_wait_rsp) | (state == s_drain)) & ~rsp_valid);

	// ******************************
	// Next state and pc
	// ******************************
	always_comb begin
		state_nxt = state;
		pc_nxt    = pc_q;
		case (state)
			s_idle: begin
				state_nxt = s_issue;
			end
			s_issue: begin
				if (issue) state_nxt = flush ? s_drain : s_wait_rsp;	// Stale fetch if flushed
			end
			s_wait_rsp: begin
				if (flush) begin
					state_nxt = rsp_valid ? s_issue : s_drain;
				end else if (rsp_valid) begin
					state_nxt = s_issue;
					pc_nxt    = next_pc;	// Target or fall through
				end
			end
			s_drain: begin
				if (rsp_valid) state_nxt = s_issue;	// Discarded, slot returned
			end
			default: state_nxt = s_idle;
		endcase
		// Flush retargets in every state
		if (flush) pc_nxt = flush_pc;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= s_idle;
			pc_q  <= boot_pc;
		end else begin
			state <= state_nxt;
			pc_q  <= pc_nxt;
		end
	end

endmodule

// File: frontend_pkg.sv
// Front end shared definitions
// Width constants of the fetch path and the branch kind carried
// with each decoded entry toward the decoder
package frontend_pkg;

	// ******************************
	// Widths
	// ******************************
	localparam int xlen    = 64;	// Address and pc width
	localparam int ilen    = 32;	// Aligned instruction width
	localparam int fetch_w = 64;	// Memory response window

	// ******************************
	// Branch kind of an entry
	// ******************************
	// Call and return win over plain jal and jalr
	typedef enum logic [2:0] {
		br_none = 3'd0,	// Not a control transfer
		br_jal  = 3'd1,	// jal or c.j, direct and always taken
		br_jalr = 3'd2,	// Indirect jump, predicted not taken
		br_cond = 3'd3,	// Conditional branch, predicted not taken
		br_call = 3'd4,	// Link to x1 or x5, c.jalr too
		br_ret  = 3'd5	// jalr x0 through x1 or x5, c.jr x1 or x5
	} br_kind_e;

endpackage
